//--- source/ahb_master_macros.svh
/*
 * Bus widths, wait timeout and burst boundary for the AHB-Lite master.
 * Included by the package and by every RTL file that sizes a bus.
 */
`ifndef AHB_MASTER_MACROS_SVH
`define AHB_MASTER_MACROS_SVH

`define AHB_ADDR_WIDTH 32

`define AHB_DATA_WIDTH 32

// consecutive low-hready cycles of one data phase before the master gives up.
`define AHB_WAIT_TIMEOUT 6

// bursts of fixed length may not cross a block of this many address bits.
`define AHB_BOUNDARY_BITS 10

`endif

//--- source/ahb_master_pkg.sv
/*
 * Bus encodings and the request, check and control structs shared by the master.
 * Every RTL file of the master imports it.
 */
`include "ahb_master_macros.svh"

package ahb_master_pkg;

    typedef enum logic [2:0] {
        HBURST_SINGLE = 3'd0,
        HBURST_INCR   = 3'd1,
        HBURST_WRAP4  = 3'd2,
        HBURST_INCR4  = 3'd3,
        HBURST_WRAP8  = 3'd4,
        HBURST_INCR8  = 3'd5,
        HBURST_WRAP16 = 3'd6,
        HBURST_INCR16 = 3'd7
    } hburst_e;

    // busy is part of the encoding but this master never drives it.
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'd0,
        HTRANS_BUSY   = 2'd1,
        HTRANS_NONSEQ = 2'd2,
        HTRANS_SEQ    = 2'd3
    } htrans_e;

    typedef struct packed {
        logic [`AHB_ADDR_WIDTH-1:0] addr;
        hburst_e                    burst;
        logic [2:0]                 size;
        logic                       write;
    } ahb_req_t;

    typedef struct packed {
        logic       legal;
        logic [4:0] beats;  // zero for an incr burst of undefined length.
    } ahb_chk_t;

    typedef struct packed {
        logic [`AHB_ADDR_WIDTH-1:0] haddr;
        htrans_e                    htrans;
        hburst_e                    hburst;
        logic [2:0]                 hsize;
        logic                       hwrite;
    } ahb_ctrl_t;

endpackage

//--- source/ahb_req_check.sv
/*
 * Combinational check of a requester's burst: alignment, size and 1 KB crossing.
 * Also gives the beat count of the burst type to the FSM.
 */
`timescale 1ns/10ps
`include "ahb_master_macros.svh"

module ahb_req_check (
    input  ahb_master_pkg::ahb_req_t req,
    output ahb_master_pkg::ahb_chk_t chk
);
    import ahb_master_pkg::*;

    localparam int AW = `AHB_ADDR_WIDTH;

    logic [4:0]    beats;
    logic [7:0]    size_bytes;
    logic [AW-1:0] span;
    logic [AW-1:0] first_byte;
    logic [AW-1:0] last_byte;
    logic          is_wrap;
    logic          fixed_len;
    logic          aligned;
    logic          size_ok;
    logic          in_block;

    always_comb begin
        case (req.burst)
            HBURST_SINGLE:                 beats = 5'd1;
            HBURST_WRAP4, HBURST_INCR4:    beats = 5'd4;
            HBURST_WRAP8, HBURST_INCR8:    beats = 5'd8;
            HBURST_WRAP16, HBURST_INCR16:  beats = 5'd16;
            default:                       beats = 5'd0;
        endcase
    end

    assign size_bytes = 8'd1 << req.size;
    assign aligned    = (req.addr[6:0] & (size_bytes[6:0] - 7'd1)) == 7'd0;
    assign size_ok    = (16'(size_bytes) << 3) <= 16'(`AHB_DATA_WIDTH);

    assign fixed_len = beats != 5'd0;
    assign is_wrap   = !req.burst[0] && req.burst != HBURST_SINGLE;
    assign span      = {{(AW-5){1'b0}}, beats} << req.size;

    // a wrapping burst covers its whole window, so the window base is the first byte.
    assign first_byte = is_wrap ? (req.addr & ~(span - AW'(1))) : req.addr;
    assign last_byte  = first_byte + span - AW'(1);
    assign in_block   = first_byte[AW-1:`AHB_BOUNDARY_BITS] == last_byte[AW-1:`AHB_BOUNDARY_BITS];

    assign chk.legal = aligned && size_ok && (!fixed_len || in_block);
    assign chk.beats = beats;

endmodule

//--- source/ahb_burst_addr.sv
/*
 * Next beat address of an incrementing or wrapping burst.
 * Fed with the live address-phase control of the FSM.
 */
`timescale 1ns/10ps
`include "ahb_master_macros.svh"

module ahb_burst_addr (
    input  ahb_master_pkg::ahb_ctrl_t      ctrl,
    output logic [`AHB_ADDR_WIDTH-1:0]     next_addr
);
    import ahb_master_pkg::*;

    localparam int AW = `AHB_ADDR_WIDTH;

    logic [AW-1:0] size_bytes;
    logic [AW-1:0] incr_addr;
    logic [AW-1:0] wrap_mask;

    assign size_bytes = AW'(1) << ctrl.hsize;
    assign incr_addr  = ctrl.haddr + size_bytes;

    // the mask selects the bits inside the wrap window of beats times size.
    always_comb begin
        case (ctrl.hburst)
            HBURST_WRAP4: begin
                wrap_mask = (size_bytes << 2) - AW'(1);
            end
            HBURST_WRAP8: begin
                wrap_mask = (size_bytes << 3) - AW'(1);
            end
            HBURST_WRAP16: begin
                wrap_mask = (size_bytes << 4) - AW'(1);
            end
            default: begin
                wrap_mask = '0;  // incrementing bursts carry through every bit.
            end
        endcase
    end

    always_comb begin
        if (wrap_mask == '0) begin
            next_addr = incr_addr;
        end else begin
            // bits above the window stay, the carry out of the window is dropped.
            next_addr = (ctrl.haddr & ~wrap_mask) | (incr_addr & wrap_mask);
        end
    end

endmodule

//--- source/ahb_xfer_fsm.sv
/*
 * Address-phase FSM of the master, issuing NONSEQ, SEQ and IDLE and counting beats.
 * It alone registers the error pulse seen by the requester.
 */
`timescale 1ns/10ps
`include "ahb_master_macros.svh"

module ahb_xfer_fsm (
    input  logic                           ahb_clk_in,
    input  logic                           ahb_rstn_in,
    input  logic                           req_valid,
    input  ahb_master_pkg::ahb_req_t       req,
    input  ahb_master_pkg::ahb_chk_t       chk,
    input  logic [`AHB_ADDR_WIDTH-1:0]     next_addr,
    input  logic                           hready,
    input  logic                           phase_error,
    output ahb_master_pkg::ahb_ctrl_t      ctrl,
    output logic                           beat_taken,
    output logic                           req_error
);
    import ahb_master_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_XFER,
        ST_ERR_HOLD,
        ST_REJ_HOLD
    } state_e;

    state_e     state;
    logic [4:0] beats_left;  // stays zero for an incr of undefined length.
    logic       addr_active;
    logic       last_beat;

    assign addr_active = ctrl.htrans == HTRANS_NONSEQ || ctrl.htrans == HTRANS_SEQ;

    // an address offered while an error is reported is not taken.
    assign beat_taken = addr_active && hready && !phase_error;

    // an undefined-length incr ends with the beat accepted while req_valid is low.
    assign last_beat = (beats_left == 5'd0) ? !req_valid : (beats_left == 5'd1);

    always_ff @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            state      <= ST_IDLE;
            ctrl       <= '0;
            beats_left <= 5'd0;
            req_error  <= 1'b0;
        end else begin
            req_error <= 1'b0;
            if (phase_error) begin
                // the burst is abandoned whatever state it is in.
                ctrl.htrans <= HTRANS_IDLE;
                req_error   <= 1'b1;
                state       <= ST_ERR_HOLD;
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (req_valid && chk.legal) begin
                            ctrl.haddr  <= req.addr;
                            ctrl.htrans <= HTRANS_NONSEQ;
                            ctrl.hburst <= req.burst;
                            ctrl.hsize  <= req.size;
                            ctrl.hwrite <= req.write;
                            beats_left  <= chk.beats;
                            state       <= ST_XFER;
                        end else if (req_valid) begin
                            req_error <= 1'b1;  // nothing reaches the bus.
                            state     <= ST_REJ_HOLD;
                        end
                    end
                    ST_XFER: begin
                        if (beat_taken && last_beat) begin
                            ctrl.htrans <= HTRANS_IDLE;
                            state       <= ST_IDLE;
                        end else if (beat_taken) begin
                            ctrl.haddr  <= next_addr;
                            ctrl.htrans <= HTRANS_SEQ;
                            if (beats_left != 5'd0) begin
                                beats_left <= beats_left - 5'd1;
                            end
                        end
                    end
                    ST_ERR_HOLD, ST_REJ_HOLD: begin
                        if (!req_valid) begin
                            state <= ST_IDLE;  // the requester has let go.
                        end
                    end
                    default: begin
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

//--- source/ahb_data_phase.sv
/*
 * Data-phase tracking of the master: write data out, read data back, errors and timeout.
 * The next address phase overlaps the pending data phase.
 */
`timescale 1ns/10ps
`include "ahb_master_macros.svh"

module ahb_data_phase (
    input  logic                           ahb_clk_in,
    input  logic                           ahb_rstn_in,
    input  ahb_master_pkg::ahb_ctrl_t      ctrl,
    input  logic [`AHB_DATA_WIDTH-1:0]     wdata,
    input  logic [`AHB_DATA_WIDTH-1:0]     hrdata,
    input  logic                           hready,
    input  logic                           hresp,
    output logic [`AHB_DATA_WIDTH-1:0]     hwdata,
    output logic                           stall,
    output logic                           beat_done,
    output logic [`AHB_DATA_WIDTH-1:0]     rdata,
    output logic                           phase_error
);
    import ahb_master_pkg::*;

    localparam int WAIT_W = $clog2(`AHB_WAIT_TIMEOUT + 1);

    logic              pending;
    logic              pend_write;
    logic              accept;
    logic              complete;
    logic [WAIT_W-1:0] wait_cnt;

    assign accept = (ctrl.htrans == HTRANS_NONSEQ || ctrl.htrans == HTRANS_SEQ)
                    && hready && !phase_error;

    assign phase_error = pending && (hresp || wait_cnt == WAIT_W'(`AHB_WAIT_TIMEOUT));
    assign complete    = pending && hready && !phase_error;
    assign stall       = pending && !hready;

    always_ff @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            pending    <= 1'b0;
            pend_write <= 1'b0;
            wait_cnt   <= '0;
            beat_done  <= 1'b0;
        end else begin
            beat_done <= complete;
            if (phase_error) begin
                pending  <= 1'b0;  // an errored phase is dropped, not retried.
                wait_cnt <= '0;
            end else if (hready) begin
                pending  <= accept;
                wait_cnt <= '0;
                if (accept) begin
                    pend_write <= ctrl.hwrite;
                end
            end else if (pending) begin
                wait_cnt <= wait_cnt + WAIT_W'(1);
            end
        end
    end

    always_ff @(posedge ahb_clk_in) begin
        if (accept && ctrl.hwrite) begin
            hwdata <= wdata;  // held through all wait states of the phase.
        end
        if (complete && !pend_write) begin
            rdata <= hrdata;
        end
    end

endmodule

//--- source/ahb_master.sv
/*
 * Top level of the AHB-Lite master, joining the requester ports to the bus.
 * Holds the request check, address FSM, burst address and data-phase blocks.
 */
`timescale 1ns/10ps
`include "ahb_master_macros.svh"

module ahb_master (
    input  logic                           ahb_clk_in,
    input  logic                           ahb_rstn_in,
    // bus side.
    output ahb_master_pkg::ahb_ctrl_t      ahb_ctrl,
    output logic [`AHB_DATA_WIDTH-1:0]     hwdata,
    input  logic [`AHB_DATA_WIDTH-1:0]     hrdata,
    input  logic                           hready,
    input  logic                           hresp,
    // requester side.
    input  logic                           req_valid,
    input  ahb_master_pkg::ahb_req_t       req,
    input  logic [`AHB_DATA_WIDTH-1:0]     wdata,
    output logic                           beat_taken,
    output logic                           stall,
    output logic                           beat_done,
    output logic [`AHB_DATA_WIDTH-1:0]     rdata,
    output logic                           req_error
);
    import ahb_master_pkg::*;

    ahb_chk_t                   chk;
    logic [`AHB_ADDR_WIDTH-1:0] next_addr;
    logic                       phase_error;

    ahb_req_check u_req_check (
        .req (req),
        .chk (chk)
    );

    ahb_xfer_fsm u_xfer_fsm (
        .ahb_clk_in  (ahb_clk_in),
        .ahb_rstn_in (ahb_rstn_in),
        .req_valid   (req_valid),
        .req         (req),
        .chk         (chk),
        .next_addr   (next_addr),
        .hready      (hready),
        .phase_error (phase_error),
        .ctrl        (ahb_ctrl),
        .beat_taken  (beat_taken),
        .req_error   (req_error)
    );

    ahb_burst_addr u_burst_addr (
        .ctrl      (ahb_ctrl),
        .next_addr (next_addr)
    );

    ahb_data_phase u_data_phase (
        .ahb_clk_in  (ahb_clk_in),
        .ahb_rstn_in (ahb_rstn_in),
        .ctrl        (ahb_ctrl),
        .wdata       (wdata),
        .hrdata      (hrdata),
        .hready      (hready),
        .hresp       (hresp),
        .hwdata      (hwdata),
        .stall       (stall),
        .beat_done   (beat_done),
        .rdata       (rdata),
        .phase_error (phase_error)
    );

endmodule

//--- tb/ahb_mem_slave.sv
/*
 * Word memory slave for the master testbench, with a set number of wait states
 * per beat and a single-cycle ERROR response on a chosen beat of each burst.
 */
`timescale 1ns/10ps

module ahb_mem_slave (
    input  logic                      ahb_clk_in,
    input  logic                      ahb_rstn_in,
    input  ahb_master_pkg::ahb_ctrl_t ctrl,
    input  logic [31:0]               hwdata,
    input  logic [3:0]                wait_states,
    input  logic [7:0]                err_beat,
    output logic [31:0]               hrdata,
    output logic                      hready,
    output logic                      hresp
);
    import ahb_master_pkg::*;

    logic [31:0] mem [0:1023];
    logic        active, write, err, accept, first;
    logic [9:0]  index;
    logic [3:0]  wait_cnt;
    logic [7:0]  beat_idx;

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = {i[9:0], 12'hc3a, ~i[9:0]};  // every word differs.
        end
    end

    assign hready = !active || wait_cnt == 4'd0;
    assign hresp  = active && err && wait_cnt == 4'd0;
    assign hrdata = mem[index];
    assign first  = ctrl.htrans == HTRANS_NONSEQ;
    assign accept = (first || ctrl.htrans == HTRANS_SEQ) && hready && !hresp;

    always_ff @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            active   <= 1'b0;
            write    <= 1'b0;
            err      <= 1'b0;
            index    <= '0;
            wait_cnt <= '0;
            beat_idx <= '0;
        end else if (!hready) begin
            wait_cnt <= wait_cnt - 4'd1;
        end else begin
            active <= accept;
            if (accept) begin
                index    <= ctrl.haddr[11:2];
                write    <= ctrl.hwrite;
                wait_cnt <= wait_states;
                err      <= (first ? 8'd0 : beat_idx) == err_beat;
                beat_idx <= first ? 8'd1 : beat_idx + 8'd1;
            end
        end
    end

    always @(posedge ahb_clk_in) begin
        if (active && hready && write && !err) begin
            mem[index] <= hwdata;
        end
    end

endmodule

//--- tb/tb_ahb_master.sv
/*
 * Testbench for the AHB-Lite master. Runs the bursts listed in the cases file
 * against a memory slave and checks addresses, beat counts, read data and errors.
 */
`timescale 1ns/10ps
`include "ahb_master_macros.svh"

module tb_ahb_master;
    import ahb_master_pkg::*;

    logic        ahb_clk_in, ahb_rstn_in, hready, hresp, req_valid;
    logic        beat_taken, stall, beat_done, req_error;
    logic [31:0] hwdata, hrdata, wdata, rdata, lfsr;
    logic [3:0]  wait_states;
    logic [7:0]  err_beat;
    ahb_ctrl_t   ahb_ctrl;
    ahb_req_t    req;
    logic [31:0] cases [0:255];
    logic [31:0] mirror [0:1023];
    int          errors, checks, limit, ncases;
    int          cycles = 0;

    ahb_master u_ahb_master (.*);

    ahb_mem_slave u_mem_slave (.ahb_clk_in, .ahb_rstn_in, .ctrl(ahb_ctrl), .hwdata,
                               .wait_states, .err_beat, .hrdata, .hready, .hresp);

    initial begin
        ahb_clk_in = 1'b0;
        forever #20 ahb_clk_in = ~ahb_clk_in;
    end

    always @(posedge ahb_clk_in) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("run stopped: cycle limit of %0d reached", limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32, 22, 2, 1.
    endfunction

    task automatic draw_word(output logic [31:0] w);
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[30:0], lfsr[0]};
        end
    endtask

    // wrapping bursts stay inside the aligned window of beats times size.
    function automatic logic [31:0] expect_next(logic [31:0] a, logic [2:0] burst,
                                                logic [2:0] size);
        logic [31:0] bytes, window, base;
        bytes = 32'd1 << size;
        window = (burst == 3'd2) ? 4 * bytes : (burst == 3'd4) ? 8 * bytes :
                 (burst == 3'd6) ? 16 * bytes : 32'd0;
        if (window == 0) return a + bytes;
        base = a - (a % window);
        return base + ((a - base + bytes) % window);
    endfunction

    function automatic int burst_beats(logic [2:0] burst, int incr_len);
        case (burst)
            3'd0: return 1;
            3'd1: return incr_len;
            3'd2, 3'd3: return 4;
            3'd4, 3'd5: return 8;
            default: return 16;
        endcase
    endfunction

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_true(logic cond, string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("ERROR at %0t: %s", $time, what);
        end
    endtask

    task automatic run_case(int b);
        logic [31:0] exp_addr, prev_haddr, prev_hwdata, a;
        logic [31:0] addr_q[$];
        int          beats, taken, done_cnt;
        logic        err_seen, nonseq_seen, prev_stall, rejected, finished, was_taken;
        beats = burst_beats(cases[b+1][2:0], cases[b+4]);
        rejected = cases[b+7][0] && cases[b+6] == 32'hff && cases[b+5] < `AHB_WAIT_TIMEOUT;
        wait_states = cases[b+5][3:0];
        err_beat = cases[b+6][7:0];
        req.write = cases[b][0];
        req.burst = hburst_e'(cases[b+1][2:0]);
        req.size = cases[b+2][2:0];
        req.addr = cases[b+3];
        req_valid = 1'b1;
        draw_word(wdata);
        exp_addr = req.addr;
        {taken, done_cnt} = '0;
        {err_seen, nonseq_seen, prev_stall, finished} = '0;
        while (!finished) begin
            @(negedge ahb_clk_in);
            was_taken = beat_taken;
            if (ahb_ctrl.htrans == HTRANS_NONSEQ) nonseq_seen = 1'b1;
            if (prev_stall) begin
                check_value("haddr", prev_haddr, ahb_ctrl.haddr);
                if (req.write) check_value("hwdata", prev_hwdata, hwdata);
            end
            if (beat_taken) begin
                check_true(!err_seen, "a beat was accepted after req_error");
                check_value("haddr", exp_addr, ahb_ctrl.haddr);
                check_value("htrans", taken == 0 ? HTRANS_NONSEQ : HTRANS_SEQ, ahb_ctrl.htrans);
                check_value("hburst", req.burst, ahb_ctrl.hburst);
                check_value("hsize", req.size, ahb_ctrl.hsize);
                check_value("hwrite", req.write, ahb_ctrl.hwrite);
                if (req.write) begin
                    mirror[exp_addr[11:2]] = wdata;
                end
                addr_q.push_back(exp_addr);
                exp_addr = expect_next(exp_addr, req.burst, req.size);
                taken++;
            end
            if (beat_done) begin
                done_cnt++;
                a = addr_q.pop_front();
                if (!req.write) begin
                    check_value("rdata", mirror[a[11:2]], rdata);
                end
            end
            if (req_error) begin
                err_seen = 1'b1;
                check_value("htrans", HTRANS_IDLE, ahb_ctrl.htrans);
            end
            // the slave only waits on a phase the master still owns until an error drops it.
            check_value("stall", !hready && !err_seen, stall);
            prev_stall = stall;
            prev_haddr = ahb_ctrl.haddr;
            prev_hwdata = hwdata;
            finished = !req_valid && ahb_ctrl.htrans == HTRANS_IDLE && hready
                       && (err_seen || done_cnt == taken);
            @(posedge ahb_clk_in);
            #2;
            if (was_taken) draw_word(wdata);
            // an undefined-length incr ends on the beat taken with req_valid low.
            if (err_seen || taken == beats || (req.burst == HBURST_INCR && taken == beats - 1))
                req_valid = 1'b0;
        end
        if (cases[b+7][0]) begin
            check_true(err_seen, "expected req_error did not occur");
        end else begin
            check_true(!err_seen, "req_error raised on a legal burst");
            check_value("beat count", beats, taken);
            check_value("beat_done count", beats, done_cnt);
        end
        if (rejected) check_true(!nonseq_seen, "a rejected request put NONSEQ on the bus");
        @(posedge ahb_clk_in);
        #2;
    endtask

    initial begin
        {ahb_rstn_in, req_valid, errors, checks, limit, ncases} = '0;
        req = '0;
        wdata = '0;
        wait_states = '0;
        err_beat = 8'hff;
        lfsr = 32'hfa5ea198;
        $readmemh("tb/ahb_master_cases.txt", cases);
        while (cases[8 * ncases] != 32'hf) begin
            limit += burst_beats(cases[8*ncases+1][2:0], cases[8*ncases+4])
                     * (cases[8*ncases+5] + 2);
            ncases++;
        end
        limit += 50;
        repeat (8) @(posedge ahb_clk_in);
        #2 ahb_rstn_in = 1'b1;
        @(negedge ahb_clk_in);
        check_value("htrans", HTRANS_IDLE, ahb_ctrl.htrans);
        check_value("hwrite", 0, ahb_ctrl.hwrite);
        check_value("outputs", 0, {beat_taken, beat_done, req_error, stall});
        @(posedge ahb_clk_in);
        #2;
        for (int c = 0; c < ncases; c++) run_case(8 * c);
        $display("cases: %0d, checks: %0d, errors: %0d", ncases, checks, errors);
        if (errors == 0) $display("=== PASS ===");
        else $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- tb/ahb_master_cases.txt
// dir(1 write) burst size addr incr_beats waits err_beat(ff none) exp_error
// one burst per line in hex, a line starting with f ends the list.
1 3 2 00000100 0 0 ff 0
0 3 2 00000100 0 0 ff 0
1 5 2 00000200 0 1 ff 0
0 5 2 00000200 0 0 ff 0
1 7 2 00000300 0 0 ff 0
0 7 2 00000300 0 2 ff 0
1 2 2 00000408 0 0 ff 0
0 2 2 00000408 0 1 ff 0
1 4 2 00000514 0 0 ff 0
0 4 2 00000514 0 0 ff 0
1 6 2 00000628 0 1 ff 0
0 6 2 00000628 0 0 ff 0
1 0 2 00000700 0 3 ff 0
0 0 2 00000700 0 2 ff 0
1 1 2 00000780 5 2 ff 0
0 1 2 00000780 5 3 ff 0
0 3 2 00000102 0 0 ff 1
0 0 3 00000100 0 0 ff 1
1 5 2 000003f0 0 0 ff 1
0 3 2 00000200 0 0 02 1
0 3 2 00000100 0 7 ff 1
0 3 2 00000100 0 0 ff 0
f 0 0 00000000 0 0 ff 0

//--- ahb_master.f
+incdir+source
source/ahb_master_pkg.sv
source/ahb_req_check.sv
source/ahb_burst_addr.sv
source/ahb_xfer_fsm.sv
source/ahb_data_phase.sv
source/ahb_master.sv
tb/ahb_mem_slave.sv
tb/tb_ahb_master.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the master testbench with Verilator; pass is decided from sim.log.
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f ahb_master.f --top-module tb_ahb_master \
    -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
{ echo "build or run failed, see build.log and sim.log"; exit 1; }
grep -qx "=== PASS ===" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
